/* hw/branchTarget.sv */
// ========================================
// redirect decision for the head slot
// combinational, zero cycles
// branch direction comes from outside
// ========================================
`timescale 1ns/1ps
`default_nettype none

module branchTarget
(
	fetchSlotIf.peer            head,
	input  var logic            predictTaken_i,
	input  var fetchPkg::pcT    retAddr_i,
	output logic                take_o,
	output fetchPkg::pcT        target_o
);

	fetchPkg::pcT brTarget;
	fetchPkg::pcT jmpTarget;

	// ========================================
	// take decision
	// ========================================

	// unconditional flow always redirects
	// conditional branch only when predicted
	always_comb
	begin
		case (head.cls)
			isaPkg::CLS_JMP,
			isaPkg::CLS_CALL,
			isaPkg::CLS_RET:    take_o = head.valid;
			isaPkg::CLS_BRANCH: take_o = head.valid & predictTaken_i;
			default:            take_o = 1'b0;
		endcase
	end

	// ========================================
	// target address
	// ========================================

	// halfword displacement in bits 31..16
	assign brTarget = head.pc + {{15{head.instr[31]}}, head.instr[31:16], 1'b0};

	// long form is absolute, short form keeps the pc's top bits
	assign jmpTarget = (head.len == 3'd6) ?
		{head.instr[38:8], 1'b0} :
		{head.pc[31:25], head.instr[31:8], 1'b0};

	always_comb
	begin
		case (head.cls)
			isaPkg::CLS_BRANCH: target_o = brTarget;
			isaPkg::CLS_JMP,
			isaPkg::CLS_CALL:   target_o = jmpTarget;
			isaPkg::CLS_RET:    target_o = retAddr_i;
			// fall through when nothing redirects
			default:            target_o = head.pc + fetchPkg::pcT'(head.len);
		endcase
	end

endmodule

`default_nettype wire

/* hw/fetchBufCtrl.sv */
// ========================================
// fetch buffer controller
// two buffers used in ping-pong order
// priority is miss, taken head, then fill
// one fetch per cycle, none when both full
// panic stays set until reset
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fetchBufCtrl
(
	input  var logic                clk,
	input  var logic                rst,
	input  var isaPkg::insnT        insnWord_i,
	input  var isaPkg::insnLenT     insnLen_i,
	input  var logic                phit_i,
	input  var logic                queued_i,
	input  var logic                branchMiss_i,
	input  var fetchPkg::pcT        missPc_i,
	input  var logic                take_i,
	input  var fetchPkg::pcT        target_i,
	input  var isaPkg::insnLenT     headLen_i,
	input  var isaPkg::insnClassE   headCls_i,
	fetchSlotIf.ctrl                head,
	output fetchPkg::pcT            pc_o,
	output fetchPkg::panicE         panic_o
);

	// ========================================
	// state
	// ========================================
	fetchPkg::pcT       pcQ;
	logic [1:0]         bufValid;
	isaPkg::insnT       bufInstr [2];
	fetchPkg::pcT       bufPc [2];
	fetchPkg::bufSelE   headSel;
	fetchPkg::bufSelE   otherSel;
	fetchPkg::bufSelE   fillSel;
	fetchPkg::panicE    panicQ;
	logic               headValid;
	logic               fillEn;

	assign otherSel  = (headSel == fetchPkg::BUF_A) ? fetchPkg::BUF_B : fetchPkg::BUF_A;
	assign headValid = bufValid[headSel];

	// an empty head means both are empty, so refill the head first
	assign fillSel = headValid ? otherSel : headSel;
	// redirects discard the word at the old pc
	assign fillEn  = phit_i & ~branchMiss_i & ~take_i & ~(headValid & bufValid[otherSel]);

	// ========================================
	// control
	// ========================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pcQ      <= fetchPkg::RESET_PC;
			bufValid <= '0;
			headSel  <= fetchPkg::BUF_A;
			panicQ   <= fetchPkg::PANIC_NONE;
		end
		else
		begin
			// issue stage took a head that was not there
			if (queued_i & ~headValid)
				panicQ <= fetchPkg::PANIC_EMPTY_QUEUE;

			if (branchMiss_i)
			begin
				// restart from the resolved address
				pcQ      <= missPc_i;
				bufValid <= '0;
				headSel  <= fetchPkg::BUF_A;
			end
			else if (take_i)
			begin
				// younger buffer is on the wrong path
				pcQ                <= target_i;
				bufValid[otherSel] <= 1'b0;
				// head lives until the issue stage takes it
				if (queued_i)
				begin
					bufValid[headSel] <= 1'b0;
					headSel           <= otherSel;
				end
			end
			else
			begin
				if (queued_i & headValid)
				begin
					bufValid[headSel] <= 1'b0;
					headSel           <= otherSel;
				end
				// fill and step pc by the word's length
				if (fillEn)
				begin
					bufValid[fillSel] <= 1'b1;
					pcQ               <= pcQ + fetchPkg::pcT'(insnLen_i);
				end
			end
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		if (fillEn)
		begin
			bufInstr[fillSel] <= insnWord_i;
			bufPc[fillSel]    <= pcQ;
		end
	end

	// ========================================
	// head steering
	// ========================================
	assign head.valid = headValid;
	assign head.instr = bufInstr[headSel];
	assign head.pc    = bufPc[headSel];
	// predecoded head fields come back from outside
	assign head.len   = headLen_i;
	assign head.cls   = headCls_i;

	assign pc_o    = pcQ;
	assign panic_o = panicQ;

endmodule

`default_nettype wire

/* hw/fetchPkg.sv */
// ========================================
// fetch stage addresses and status codes
// byte addresses are 32 bits wide
// return stack depth must match the pointer
// ========================================
`default_nettype none

package fetchPkg;

	// byte address of an instruction
	typedef logic [31:0] pcT;

	// first fetch address after reset
	localparam pcT RESET_PC = 32'h0000_0100;

	// return stack entries, a power of two
	localparam int RSB_DEPTH = 4;
	typedef logic [1:0] rsbPtrT;

	// sticky error report
	typedef enum logic [3:0] {
		PANIC_NONE        = 4'd0,
		PANIC_EMPTY_QUEUE = 4'd1
	} panicE;

	// which fetch buffer holds the older instruction
	typedef enum logic {
		BUF_A = 1'b0,
		BUF_B = 1'b1
	} bufSelE;

endpackage

`default_nettype wire

/* hw/fetchSlotIf.sv */
// ========================================
// head fetch buffer slot
// driven by the buffer controller only
// len and cls are the predecoded head word
// ========================================
`timescale 1ns/1ps
`default_nettype none

interface fetchSlotIf;

	logic                valid;
	isaPkg::insnT        instr;
	fetchPkg::pcT        pc;
	isaPkg::insnLenT     len;
	isaPkg::insnClassE   cls;

	// buffer controller side
	modport ctrl (output valid, instr, pc, len, cls);
	// consumers of the head slot
	modport peer (input valid, instr, pc, len, cls);

endinterface

`default_nettype wire

/* hw/fetchTop.sv */
// ========================================
// fetch stage top level
// instruction memory answers in the same cycle
// queued_i and branchMiss_i are strobes
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fetchTop
(
	input  var logic                clk,
	input  var logic                rst,
	input  var isaPkg::insnT        insn_i,
	input  var logic                phit_i,
	input  var logic                queued_i,
	input  var logic                predictTaken_i,
	input  var logic                branchMiss_i,
	input  var fetchPkg::pcT        missPc_i,
	output fetchPkg::pcT            pc_o,
	output logic                    headValid_o,
	output isaPkg::insnT            headInstr_o,
	output fetchPkg::pcT            headPc_o,
	output isaPkg::insnLenT         headLen_o,
	output fetchPkg::panicE         panic_o
);

	isaPkg::insnLenT    fetchLen;
	isaPkg::insnLenT    headLen;
	isaPkg::insnClassE  headCls;
	logic               take;
	fetchPkg::pcT       target;
	fetchPkg::pcT       retAddr;

	// head slot shared by controller, target and stack
	fetchSlotIf headSlot ();

	fetchBufCtrl i_ctrl (
		.clk(clk), .rst(rst),
		.insnWord_i(insn_i), .insnLen_i(fetchLen), .phit_i(phit_i),
		.queued_i(queued_i), .branchMiss_i(branchMiss_i), .missPc_i(missPc_i),
		.take_i(take), .target_i(target),
		.headLen_i(headLen), .headCls_i(headCls),
		.head(headSlot.ctrl), .pc_o(pc_o), .panic_o(panic_o)
	);

	insnPredecode i_predecode (
		.fetchInsn_i(insn_i), .headInsn_i(headSlot.instr),
		.fetchLen_o(fetchLen), .headLen_o(headLen), .headCls_o(headCls)
	);

	branchTarget i_target (
		.head(headSlot.peer), .predictTaken_i(predictTaken_i),
		.retAddr_i(retAddr), .take_o(take), .target_o(target)
	);

	returnStack i_rsb (
		.clk(clk), .rst(rst), .head(headSlot.peer),
		.queued_i(queued_i), .top_o(retAddr)
	);

	// head slot to the issue stage
	assign headValid_o = headSlot.valid;
	assign headInstr_o = headSlot.instr;
	assign headPc_o    = headSlot.pc;
	assign headLen_o   = headSlot.len;

endmodule

`default_nettype wire

/* hw/insnPredecode.sv */
// ========================================
// length and class predecode
// purely combinational
// 2-byte words are sized only
// ========================================
`timescale 1ns/1ps
`default_nettype none

module insnPredecode
(
	input  var isaPkg::insnT      fetchInsn_i,
	input  var isaPkg::insnT      headInsn_i,
	output isaPkg::insnLenT       fetchLen_o,
	output isaPkg::insnLenT       headLen_o,
	output isaPkg::insnClassE     headCls_o
);

	// length field in bits 7..6
	function automatic isaPkg::insnLenT lenOf(input isaPkg::insnT w);
		case (w[7:6])
			2'd0:    lenOf = 3'd4;
			2'd1:    lenOf = 3'd6;
			// both compressed encodings
			default: lenOf = 3'd2;
		endcase
	endfunction

	// flow class from the opcode
	function automatic isaPkg::insnClassE clsOf(input isaPkg::insnT w);
		case (isaPkg::opcodeT'(w[5:0]))
			isaPkg::OP_BCC:  clsOf = isaPkg::CLS_BRANCH;
			isaPkg::OP_JMP:  clsOf = isaPkg::CLS_JMP;
			isaPkg::OP_CALL: clsOf = isaPkg::CLS_CALL;
			isaPkg::OP_RET:  clsOf = isaPkg::CLS_RET;
			default:         clsOf = isaPkg::CLS_PLAIN;
		endcase
	endfunction

	// incoming word sizes the pc step
	assign fetchLen_o = lenOf(fetchInsn_i);

	// head word feeds steering and the return stack
	assign headLen_o = lenOf(headInsn_i);
	assign headCls_o = clsOf(headInsn_i);

endmodule

`default_nettype wire

/* hw/isaPkg.sv */
// ========================================
// instruction set view of the fetch stage
// 48-bit words, length field in bits 7..6
// opcode in bits 5..0
// compressed words are sized, not expanded
// ========================================
`default_nettype none

package isaPkg;

	// full instruction word as fetched
	typedef logic [47:0] insnT;
	// primary opcode field
	typedef logic [5:0] opcodeT;
	// instruction length in bytes (2, 4 or 6)
	typedef logic [2:0] insnLenT;

	// ========================================
	// opcodes seen by the fetch stage
	// ========================================
	localparam opcodeT OP_BCC  = 6'h30;
	localparam opcodeT OP_JMP  = 6'h28;
	localparam opcodeT OP_CALL = 6'h29;
	localparam opcodeT OP_RET  = 6'h2A;
	localparam opcodeT OP_NOP  = 6'h3D;

	// flow class used for steering and the return stack
	typedef enum logic [2:0] {
		CLS_PLAIN  = 3'd0,
		CLS_BRANCH = 3'd1,
		CLS_JMP    = 3'd2,
		CLS_CALL   = 3'd3,
		CLS_RET    = 3'd4
	} insnClassE;

endpackage

`default_nettype wire

/* hw/returnStack.sv */
// ========================================
// circular return address stack
// oldest entry is lost when full
// an empty stack returns the reset address
// no repair after a branch miss
// ========================================
`timescale 1ns/1ps
`default_nettype none

module returnStack
(
	input  var logic            clk,
	input  var logic            rst,
	fetchSlotIf.peer            head,
	input  var logic            queued_i,
	output fetchPkg::pcT        top_o
);

	fetchPkg::pcT                       stack [fetchPkg::RSB_DEPTH];
	logic [fetchPkg::RSB_DEPTH-1:0]     entryValid;
	fetchPkg::rsbPtrT                   topPtr;
	fetchPkg::rsbPtrT                   pushPtr;
	logic                               doPush;
	logic                               doPop;

	// only a head the issue stage accepts moves the stack
	assign doPush  = queued_i & head.valid & (head.cls == isaPkg::CLS_CALL);
	assign doPop   = queued_i & head.valid & (head.cls == isaPkg::CLS_RET);
	// pointer wraps, which overwrites the oldest entry
	assign pushPtr = topPtr + 1'b1;

	// control state
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			topPtr     <= '0;
			entryValid <= '0;
		end
		else if (doPush)
		begin
			topPtr              <= pushPtr;
			entryValid[pushPtr] <= 1'b1;
		end
		else if (doPop)
		begin
			topPtr             <= topPtr - 1'b1;
			entryValid[topPtr] <= 1'b0;
		end
	end

	// return address is the byte after the call
	always_ff @(posedge clk)
	begin
		if (doPush)
			stack[pushPtr] <= head.pc + fetchPkg::pcT'(head.len);
	end

	assign top_o = entryValid[topPtr] ? stack[topPtr] : fetchPkg::RESET_PC;

endmodule

`default_nettype wire

/* verification/fetchTb.sv */
// ========================================
// fetch stage testbench
// program image is a 4 KiB byte array, addresses wrap
// bit 8 of a BCC word is its taken hint
// stops at the first mismatch
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fetchTb;

	logic               clk;
	logic               rst;
	isaPkg::insnT       insn_i;
	logic               phit_i;
	logic               queued_i;
	logic               predictTaken_i;
	logic               branchMiss_i;
	fetchPkg::pcT       missPc_i;
	fetchPkg::pcT       pc_o;
	logic               headValid_o;
	isaPkg::insnT       headInstr_o;
	fetchPkg::pcT       headPc_o;
	isaPkg::insnLenT    headLen_o;
	fetchPkg::panicE    panic_o;

	logic [7:0]         mem [4096];
	logic [31:0]        lfsr;
	// next program-order pc and shadow return stack
	fetchPkg::pcT       expPc;
	fetchPkg::pcT       rsModel [$];
	fetchPkg::pcT       missTargets [4] = '{32'h100, 32'h200, 32'h506, 32'h124};
	int                 queuedCount;

	fetchTop i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// failure reporting
	// ========================================
	task automatic stopOnFail();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [47:0] got,
		input logic [47:0] exp);
		$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
		stopOnFail();
	endtask

	task automatic reportTimeout(input string what);
		$display("timed out waiting for %s", what);
		stopOnFail();
	endtask

	// issue stage taking an empty head must raise panic
	assert property (@(posedge clk) disable iff (rst)
		queued_i && !headValid_o |=> panic_o == fetchPkg::PANIC_EMPTY_QUEUE)
	else
	begin
		$display("[FAIL] panic_o got 0x%0h expected 0x%0h", panic_o,
			fetchPkg::PANIC_EMPTY_QUEUE);
		stopOnFail();
	end

	// panic is sticky until reset
	assert property (@(posedge clk) disable iff (rst)
		panic_o == fetchPkg::PANIC_EMPTY_QUEUE |=> panic_o == fetchPkg::PANIC_EMPTY_QUEUE)
	else
	begin
		$display("[FAIL] panic_o got 0x%0h expected 0x%0h", panic_o,
			fetchPkg::PANIC_EMPTY_QUEUE);
		stopOnFail();
	end

	// ========================================
	// random source and memory model
	// ========================================

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randBits(input int n, output int unsigned v);
		v = 0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsrStep(lfsr);
			v = (v << 1) | lfsr[0];
		end
	endtask

	// 0 -> 4 bytes, 1 -> 6 bytes, 2 or 3 -> 2 bytes
	function automatic isaPkg::insnLenT lenOfWord(input isaPkg::insnT w);
		if (w[7:6] == 2'd0)
			return 3'd4;
		if (w[7:6] == 2'd1)
			return 3'd6;
		return 3'd2;
	endfunction

	// little endian, six bytes from the address
	function automatic isaPkg::insnT wordAt(input fetchPkg::pcT a);
		isaPkg::insnT w;
		for (int k = 0; k < 6; k++)
			w[k*8 +: 8] = mem[12'(a + k)];
		return w;
	endfunction

	// memory answers in the same cycle
	always_comb
		insn_i = wordAt(pc_o);

	task automatic putInsn(input fetchPkg::pcT a, input logic [1:0] lenCode,
		input isaPkg::opcodeT op, input logic [39:0] payload);
		isaPkg::insnT w;
		w = {payload, lenCode, op};
		for (int k = 0; k < int'(lenOfWord(w)); k++)
			mem[12'(a + k)] = w[k*8 +: 8];
	endtask

	task automatic loadProgram();
		logic [31:0] a;
		for (int i = 0; i < 4096; i++)
		begin
			a = i;
			mem[i] = a[7:0] ^ a[11:4] ^ 8'h5A;
		end
		// main loop, mixed lengths and both BCC outcomes
		putInsn(32'h100, 2'd0, isaPkg::OP_NOP, 40'h0);
		putInsn(32'h104, 2'd2, 6'h01, 40'h12);
		putInsn(32'h106, 2'd1, 6'h02, 40'h34_5678_9abc);
		putInsn(32'h10C, 2'd0, isaPkg::OP_BCC, {16'h0, 16'h0008, 8'h00});
		putInsn(32'h110, 2'd0, isaPkg::OP_BCC, {16'h0, 16'h0008, 8'h01});
		putInsn(32'h114, 2'd0, 6'h03, 40'h77);
		putInsn(32'h120, 2'd0, isaPkg::OP_CALL, {16'h0, 24'h000100});
		putInsn(32'h124, 2'd3, 6'h04, 40'h0);
		putInsn(32'h126, 2'd1, isaPkg::OP_JMP, 40'h80);
		// four nested calls, 0x200 -> 0x300 -> 0x400 -> 0x500
		putInsn(32'h200, 2'd2, 6'h05, 40'h0);
		putInsn(32'h202, 2'd1, isaPkg::OP_CALL, 40'h180);
		putInsn(32'h208, 2'd2, isaPkg::OP_RET, 40'h0);
		putInsn(32'h300, 2'd0, isaPkg::OP_CALL, {16'h0, 24'h000200});
		putInsn(32'h304, 2'd0, isaPkg::OP_RET, 40'h0);
		putInsn(32'h400, 2'd0, isaPkg::OP_CALL, {16'h0, 24'h000280});
		putInsn(32'h404, 2'd3, isaPkg::OP_RET, 40'h0);
		putInsn(32'h500, 2'd1, 6'h06, 40'hff_0000_0001);
		putInsn(32'h506, 2'd0, isaPkg::OP_BCC, {16'h0, 16'h0005, 8'h01});
		putInsn(32'h50A, 2'd2, 6'h07, 40'h0);
		putInsn(32'h510, 2'd0, isaPkg::OP_RET, 40'h0);
	endtask

	// ========================================
	// reference model
	// ========================================
	task automatic advanceModel(input isaPkg::insnT w);
		fetchPkg::pcT   fall;
		isaPkg::opcodeT op;
		fall = expPc + fetchPkg::pcT'(lenOfWord(w));
		op   = w[5:0];
		if (op == isaPkg::OP_CALL)
		begin
			rsModel.push_back(fall);
			// oldest return address is lost
			if (rsModel.size() > fetchPkg::RSB_DEPTH)
				rsModel.delete(0);
		end
		// displacement counts halfwords
		if (op == isaPkg::OP_BCC)
			expPc = w[8] ? expPc + 32'(signed'(w[31:16])) * 2 : fall;
		else if (op == isaPkg::OP_JMP || op == isaPkg::OP_CALL)
			expPc = (lenOfWord(w) == 3'd6) ? fetchPkg::pcT'(w[47:8] << 1) :
				(expPc & 32'hfe00_0000) | (fetchPkg::pcT'(w[31:8]) << 1);
		else if (op == isaPkg::OP_RET && rsModel.size() == 0)
			expPc = fetchPkg::RESET_PC;
		else if (op == isaPkg::OP_RET)
			expPc = rsModel.pop_back();
		else
			expPc = fall;
	endtask

	task automatic checkHead();
		isaPkg::insnT w;
		w = wordAt(expPc);
		assert (headPc_o == expPc) else reportMismatch("headPc_o", headPc_o, expPc);
		assert (headInstr_o == w) else reportMismatch("headInstr_o", headInstr_o, w);
		assert (headLen_o == lenOfWord(w))
			else reportMismatch("headLen_o", headLen_o, lenOfWord(w));
		advanceModel(w);
	endtask

	// ========================================
	// stimulus
	// ========================================

	// called right after a falling edge
	task automatic driveInputs(input logic ph, input logic q, input logic bm,
		input fetchPkg::pcT mp);
		phit_i         = ph;
		queued_i       = q;
		branchMiss_i   = bm;
		missPc_i       = mp;
		predictTaken_i = headValid_o & headInstr_o[8];
	endtask

	task automatic applyReset();
		rst = 1'b1;
		driveInputs(1'b0, 1'b0, 1'b0, 32'h0);
		predictTaken_i = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		assert (headValid_o == 1'b0) else reportMismatch("headValid_o", headValid_o, 0);
		assert (panic_o == fetchPkg::PANIC_NONE)
			else reportMismatch("panic_o", panic_o, fetchPkg::PANIC_NONE);
		assert (pc_o == fetchPkg::RESET_PC)
			else reportMismatch("pc_o", pc_o, fetchPkg::RESET_PC);
		rsModel.delete();
		expPc = fetchPkg::RESET_PC;
	endtask

	// fetch with random hits until a head shows up
	task automatic waitHead(input int limit);
		int unsigned r;
		int          n;
		n = 0;
		while (!headValid_o)
		begin
			if (n == limit)
				reportTimeout("a valid head after a branch miss");
			randBits(2, r);
			driveInputs(r != 0, 1'b0, 1'b0, 32'h0);
			@(negedge clk);
			n++;
		end
	endtask

	task automatic runRandom(input int count, input int limit);
		int unsigned  r;
		int unsigned  sel;
		int           cycles;
		logic         q;
		fetchPkg::pcT mp;
		cycles      = 0;
		queuedCount = 0;
		while (queuedCount < count)
		begin
			if (cycles == limit)
				reportTimeout("the issue stage to take all heads");
			assert (panic_o == fetchPkg::PANIC_NONE)
				else reportMismatch("panic_o", panic_o, fetchPkg::PANIC_NONE);
			randBits(6, r);
			if (r == 0)
			begin
				// resolved miss restarts the fetch
				randBits(2, sel);
				mp = missTargets[sel];
				driveInputs(1'b1, 1'b0, 1'b1, mp);
				@(negedge clk);
				branchMiss_i = 1'b0;
				waitHead(50);
				assert (headPc_o == mp) else reportMismatch("headPc_o", headPc_o, mp);
				expPc = mp;
			end
			else
			begin
				randBits(2, r);
				randBits(1, sel);
				q = headValid_o & sel[0];
				if (q)
				begin
					checkHead();
					queuedCount++;
				end
				driveInputs(r != 0, q, 1'b0, 32'h0);
				@(negedge clk);
			end
			cycles++;
		end
	endtask

	// flush both buffers, then take a head that is not there
	task automatic checkPanic();
		int unsigned r;
		driveInputs(1'b0, 1'b0, 1'b1, fetchPkg::RESET_PC);
		@(negedge clk);
		assert (headValid_o == 1'b0) else reportMismatch("headValid_o", headValid_o, 0);
		driveInputs(1'b0, 1'b1, 1'b0, 32'h0);
		@(negedge clk);
		for (int k = 0; k < 20; k++)
		begin
			assert (panic_o == fetchPkg::PANIC_EMPTY_QUEUE)
				else reportMismatch("panic_o", panic_o, fetchPkg::PANIC_EMPTY_QUEUE);
			randBits(2, r);
			driveInputs(r != 0, 1'b0, 1'b0, 32'h0);
			@(negedge clk);
		end
	endtask

	initial
	begin
		lfsr           = 32'hce8c_f313;
		rst            = 1'b1;
		phit_i         = 1'b0;
		queued_i       = 1'b0;
		predictTaken_i = 1'b0;
		branchMiss_i   = 1'b0;
		missPc_i       = '0;
		loadProgram();
		applyReset();
		runRandom(400, 20000);
		checkPanic();
		// reset must clear the sticky panic
		applyReset();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/isaPkg.sv
hw/fetchPkg.sv
hw/fetchSlotIf.sv
hw/insnPredecode.sv
hw/branchTarget.sv
hw/returnStack.sv
hw/fetchBufCtrl.sv
hw/fetchTop.sv
verification/fetchTb.sv
